/* files.f */
design/ntm_output_pkg.sv
design/ntm_output_apb_regs.sv
design/ntm_output_operand_fetch.sv
design/ntm_output_mac.sv
design/ntm_output_writeback.sv
design/ntm_controller_output_vector.sv
bench/ntm_output_chk.sv
bench/ntm_output_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the NTM output vector testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

log=sim.log

# Any build error or assertion stop ends here with a failing status
verilator --binary --timing --assert -j 0 \
  --top-module ntm_output_tb -f files.f -o ntm_output_sim > "$log" 2>&1 &&
  ./obj_dir/ntm_output_sim >> "$log" 2>&1 ||
  { echo "build or simulation error, see $log"; exit 1; }

# Verdict comes from the log
grep -q "CHECKS FAILED" "$log" &&
  { echo "simulation reported failures, see $log"; exit 1; } ||
  { echo "simulation clean, see $log"; exit 0; }

/* bench/ntm_output_tb.sv */
`timescale 1ns/1ns

module ntm_output_tb;
  import ntm_output_pkg::*;

  localparam int clk_period      = 10;
  localparam int reset_cycles    = 10;
  localparam int test_count      = 6;
  localparam int max_test_cycles = 700;
  // Spare cycles for reset and status polling
  localparam int watchdog_ns = (test_count * max_test_cycles + 800) * clk_period;

  localparam logic [9:0] addr_ctrl   = 10'h000;
  localparam logic [9:0] addr_status = 10'h004;
  localparam logic [9:0] addr_size_y = 10'h008;
  localparam logic [9:0] addr_size_l = 10'h00C;

  logic        clk;
  logic        rst_n;
  logic [9:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Mirror of the operand memories
  ntm_data_t u_model [ntm_max_dim*ntm_max_dim];
  ntm_data_t h_model [ntm_max_dim];
  int        checks;
  int        errors;

  ntm_controller_output_vector u_ntm_controller_output_vector (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(clk_period/2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // APB access
  ////////////////////////////////////////////////////////////

  function automatic logic [9:0] u_addr(int row, int col);
    return {region_u_mat, 3'(row), 3'(col), 2'b00};
  endfunction

  function automatic logic [9:0] vec_addr(ntm_region_e region, int idx);
    return {region, 3'b000, 3'(idx), 2'b00};
  endfunction

  // Setup cycle, access phase, sample at the falling edge
  task automatic apb_access(logic [9:0] addr, logic wr, logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(logic [9:0] addr, logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(addr, 1'b1, data, unused, err);
  endtask

  task automatic apb_read(logic [9:0] addr, output logic [31:0] data, output logic err);
    apb_access(addr, 1'b0, 32'd0, data, err);
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(string what, ntm_data_t got, ntm_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_size(string what, ntm_size_t got, ntm_size_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_err(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: pslverr %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_cycles(string what, int got, int max_cycles);
    checks++;
    if (got > max_cycles) begin
      errors++;
      $display("FAILED t=%0t %s: took %0d cycles, limit %0d", $time, what, got, max_cycles);
    end
  endtask

  task automatic write_checked(logic [9:0] addr, logic [31:0] data, logic exp_err, string what);
    logic err;
    apb_write(addr, data, err);
    check_err(what, err, exp_err);
  endtask

  task automatic report_test(string name, int errs_at_start);
    $display("test %-14s %s", name, (errors == errs_at_start) ? "passed" : "failed");
  endtask

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // nu(y) = sum over l of U(y,l)*h(l), wrapped to 16 bits
  function automatic ntm_data_t expected_nu(int y, int nl);
    logic [31:0] prod;
    ntm_data_t   acc;
    acc = '0;
    for (int l = 0; l < nl; l++) begin
      prod = 32'(u_model[y*ntm_max_dim+l]) * 32'(h_model[l]);
      acc  = acc + prod[15:0];
    end
    return acc;
  endfunction

  task automatic set_sizes(int ny, int nl);
    write_checked(addr_size_y, 32'(ny), 1'b0, "SIZE_Y write");
    write_checked(addr_size_l, 32'(nl), 1'b0, "SIZE_L write");
  endtask

  // Fresh random values only in the covered cells
  task automatic load_operands(int ny, int nl);
    logic [31:0] rnd;
    for (int y = 0; y < ny; y++) begin
      for (int l = 0; l < nl; l++) begin
        rnd = $urandom();
        u_model[y*ntm_max_dim+l] = rnd[15:0];
        write_checked(u_addr(y, l), {16'd0, rnd[15:0]}, 1'b0, "U write");
      end
    end
    for (int l = 0; l < nl; l++) begin
      rnd = $urandom();
      h_model[l] = rnd[15:0];
      write_checked(vec_addr(region_h_vec, l), {16'd0, rnd[15:0]}, 1'b0, "h write");
    end
  endtask

  // Poll STATUS until done, then expect done without busy
  task automatic wait_done();
    logic [31:0] data;
    logic        err;
    apb_read(addr_status, data, err);
    while (!data[1]) begin
      apb_read(addr_status, data, err);
    end
    check_data("STATUS at done", data[15:0], 16'd2);
  endtask

  task automatic compare_results(int ny, int nl);
    logic [31:0] data;
    logic        err;
    for (int y = 0; y < ny; y++) begin
      apb_read(vec_addr(region_nu_vec, y), data, err);
      check_data($sformatf("nu[%0d]", y), data[15:0], expected_nu(y, nl));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    int          errs_at_start;
    logic [31:0] data;
    logic        err;
    errs_at_start = errors;
    apb_read(addr_size_y, data, err);
    check_size("SIZE_Y after reset", data[3:0], 4'd1);
    apb_read(addr_size_l, data, err);
    check_size("SIZE_L after reset", data[3:0], 4'd1);
    apb_read(addr_status, data, err);
    check_data("STATUS after reset", data[15:0], 16'd0);
    report_test("reset_values", errs_at_start);
  endtask

  task automatic test_size_range();
    int          errs_at_start;
    logic [31:0] data;
    logic        err;
    errs_at_start = errors;
    write_checked(addr_size_y, 32'd0, 1'b1, "SIZE_Y write 0");
    apb_read(addr_size_y, data, err);
    check_size("SIZE_Y kept", data[3:0], 4'd1);
    write_checked(addr_size_l, 32'd9, 1'b1, "SIZE_L write 9");
    apb_read(addr_size_l, data, err);
    check_size("SIZE_L kept", data[3:0], 4'd1);
    write_checked(addr_size_y, 32'd5, 1'b0, "SIZE_Y write 5");
    apb_read(addr_size_y, data, err);
    check_size("SIZE_Y readback", data[3:0], 4'd5);
    report_test("size_range", errs_at_start);
  endtask

  task automatic test_product(string name, int ny, int nl);
    int errs_at_start;
    errs_at_start = errors;
    set_sizes(ny, nl);
    load_operands(ny, nl);
    write_checked(addr_ctrl, 32'd1, 1'b0, "start");
    wait_done();
    compare_results(ny, nl);
    report_test(name, errs_at_start);
  endtask

  task automatic test_busy_writes();
    int          errs_at_start;
    time         t_start;
    logic [31:0] data;
    logic        err;
    errs_at_start = errors;
    set_sizes(8, 8);
    write_checked(addr_ctrl, 32'd1, 1'b0, "start");
    t_start = $time;
    // Run of 64 pairs is still in flight here
    write_checked(u_addr(0, 0), 32'hFFFF, 1'b1, "U write while busy");
    write_checked(vec_addr(region_h_vec, 0), 32'hFFFF, 1'b1, "h write while busy");
    write_checked(addr_size_y, 32'd4, 1'b1, "SIZE_Y write while busy");
    write_checked(addr_ctrl, 32'd1, 1'b0, "second start");
    apb_read(addr_status, data, err);
    check_data("STATUS while busy", data[15:0], 16'd1);
    wait_done();
    // Done Y*L+3 cycles after the first start, plus one STATUS poll
    check_cycles("done after ignored second start",
                 int'(($time - t_start) / clk_period), 8 * 8 + 3 + 3);
    compare_results(8, 8);
    apb_read(u_addr(0, 0), data, err);
    check_data("U[0][0] unchanged", data[15:0], u_model[0]);
    report_test("busy_writes", errs_at_start);
  endtask

  task automatic test_read_only();
    int          errs_at_start;
    logic [31:0] data;
    logic        err;
    errs_at_start = errors;
    write_checked(vec_addr(region_nu_vec, 2), 32'h1234, 1'b1, "nu write");
    write_checked(addr_status, 32'd0, 1'b1, "STATUS write");
    apb_read(addr_status, data, err);
    check_data("STATUS kept", data[15:0], 16'd2);
    compare_results(8, 8);
    report_test("read_only", errs_at_start);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    #(watchdog_ns);
    $display("Timeout: tests did not finish within %0d ns", watchdog_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h5de15f21));
    clk     = 1'b0;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    checks  = 0;
    errors  = 0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_values();
    test_size_range();
    test_product("full_8x8", 8, 8);
    // Cells outside 3x5 keep stale data from the 8x8 run
    test_product("partial_3x5", 3, 5);
    test_busy_writes();
    test_read_only();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* bench/ntm_output_chk.sv */
`timescale 1ns/1ns

module ntm_output_chk (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      psel,
  input logic                      penable,
  input logic                      pready,
  input logic                      pslverr,
  input logic                      is_nu,
  input logic                      start,
  input logic                      busy,
  input logic                      done,
  input ntm_output_pkg::ntm_size_t size_y,
  input ntm_output_pkg::ntm_size_t size_l
);

  // Rejected write leaves the size registers alone
  a_err_keeps_sizes: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |=> ($stable(size_y) && $stable(size_l)))
    else $error("size register changed on an error response");

  // Start clears done and raises busy
  a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start |=> (busy && !done))
    else $error("busy or done wrong after start");

  // nu access waits one cycle, no more
  a_nu_one_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && is_nu && !pready) |=> pready)
    else $error("nu access phase longer than one wait state");

  // Idle right after reset release
  a_idle_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !busy)
    else $error("busy high after reset release");

endmodule

bind ntm_output_apb_regs ntm_output_chk u_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .is_nu   (is_nu),
  .start   (start),
  .busy    (busy),
  .done    (done),
  .size_y  (size_y),
  .size_l  (size_l)
);

/* design/ntm_controller_output_vector.sv */
`timescale 1ns/1ns

module ntm_controller_output_vector (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [9:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  import ntm_output_pkg::*;

  // Control from the register block
  logic       start;
  ntm_size_t  size_y;
  ntm_size_t  size_l;

  // Operand read port
  ntm_idx_t   rd_row;
  ntm_idx_t   rd_col;
  ntm_data_t  u_word;
  ntm_data_t  h_word;

  // Pipeline records
  ntm_fetch_s fetch;
  ntm_nu_s    nu;

  // Result side
  logic       done;
  ntm_idx_t   nu_addr;
  ntm_data_t  nu_word;

  ntm_output_apb_regs u_apb_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .size_y  (size_y),
    .size_l  (size_l),
    .rd_row  (rd_row),
    .rd_col  (rd_col),
    .u_word  (u_word),
    .h_word  (h_word),
    .done    (done),
    .nu_addr (nu_addr),
    .nu_word (nu_word)
  );

  // Stage 1
  ntm_output_operand_fetch u_operand_fetch (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .size_y (size_y),
    .size_l (size_l),
    .rd_row (rd_row),
    .rd_col (rd_col),
    .u_word (u_word),
    .h_word (h_word),
    .fetch  (fetch)
  );

  // Stage 2
  ntm_output_mac u_mac (
    .clk   (clk),
    .rst_n (rst_n),
    .fetch (fetch),
    .nu    (nu)
  );

  // Stage 3
  ntm_output_writeback u_writeback (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .size_y  (size_y),
    .nu      (nu),
    .done    (done),
    .nu_addr (nu_addr),
    .nu_word (nu_word)
  );

endmodule

/* design/ntm_output_writeback.sv */
`timescale 1ns/1ns

module ntm_output_writeback (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  ntm_output_pkg::ntm_size_t size_y,
  input  ntm_output_pkg::ntm_nu_s   nu,
  output logic                      done,
  input  ntm_output_pkg::ntm_idx_t  nu_addr,
  output ntm_output_pkg::ntm_data_t nu_word
);
  import ntm_output_pkg::*;

  ntm_data_t nu_mem [ntm_max_dim];
  ntm_size_t size_y_q;
  ntm_size_t rows_q;

  ////////////////////////////////////////////////////////////
  // Result memory and completion
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done     <= 1'b0;
      rows_q   <= '0;
      size_y_q <= 4'd1;
      for (int i = 0; i < ntm_max_dim; i++) begin
        nu_mem[i] <= '0;
      end
    end else begin
      if (start) begin
        // New run clears the row count and done
        done     <= 1'b0;
        rows_q   <= '0;
        size_y_q <= size_y;
      end else if (nu.valid) begin
        rows_q <= rows_q + 4'd1;
        // Last row written
        if (rows_q + 4'd1 == size_y_q) begin
          done <= 1'b1;
        end
      end
      if (nu.valid) begin
        nu_mem[nu.row] <= nu.value;
      end
    end
  end

  // Registered read port for APB
  always_ff @(posedge clk) begin
    nu_word <= nu_mem[nu_addr];
  end

endmodule

/* design/ntm_output_mac.sv */
`timescale 1ns/1ns

module ntm_output_mac (
  input  logic                       clk,
  input  logic                       rst_n,
  input  ntm_output_pkg::ntm_fetch_s fetch,
  output ntm_output_pkg::ntm_nu_s    nu
);
  import ntm_output_pkg::*;

  ntm_data_t product;
  ntm_data_t sum;
  ntm_data_t acc_q;
  ntm_nu_s   nu_q;

  ////////////////////////////////////////////////////////////
  // Multiply and accumulate
  ////////////////////////////////////////////////////////////

  // Low half of the product only, sums wrap at 2^16
  assign product = fetch.u * fetch.h;

  // First column of a row restarts the sum
  assign sum = fetch.first ? product : acc_q + product;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nu_q.valid <= 1'b0;
    end else begin
      // Hold the running sum between valid pairs
      if (fetch.valid) begin
        acc_q <= sum;
      end
      // Emit once per row on its last column
      nu_q.valid <= fetch.valid & fetch.last;
      nu_q.row   <= fetch.row;
      nu_q.value <= sum;
    end
  end

  assign nu = nu_q;

endmodule

/* design/ntm_output_operand_fetch.sv */
`timescale 1ns/1ns

module ntm_output_operand_fetch (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  ntm_output_pkg::ntm_size_t  size_y,
  input  ntm_output_pkg::ntm_size_t  size_l,
  output ntm_output_pkg::ntm_idx_t   rd_row,
  output ntm_output_pkg::ntm_idx_t   rd_col,
  input  ntm_output_pkg::ntm_data_t  u_word,
  input  ntm_output_pkg::ntm_data_t  h_word,
  output ntm_output_pkg::ntm_fetch_s fetch
);
  import ntm_output_pkg::*;

  ntm_size_t  size_y_q;
  ntm_size_t  size_l_q;
  ntm_idx_t   row_q;
  ntm_idx_t   col_q;
  logic       active_q;
  logic       row_last;
  logic       col_last;
  ntm_fetch_s fetch_q;

  ////////////////////////////////////////////////////////////
  // Index scan
  ////////////////////////////////////////////////////////////

  // End of row and end of matrix
  assign col_last = ({1'b0, col_q} == size_l_q - 4'd1);
  assign row_last = ({1'b0, row_q} == size_y_q - 4'd1);

  // y outer, l inner, one pair per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      row_q    <= '0;
      col_q    <= '0;
      size_y_q <= 4'd1;
      size_l_q <= 4'd1;
    end else if (start) begin
      active_q <= 1'b1;
      row_q    <= '0;
      col_q    <= '0;
      size_y_q <= size_y;
      size_l_q <= size_l;
    end else if (active_q) begin
      if (col_last) begin
        col_q <= '0;
        if (row_last) begin
          active_q <= 1'b0;
        end else begin
          row_q <= row_q + 3'd1;
        end
      end else begin
        col_q <= col_q + 3'd1;
      end
    end
  end

  // Memory read address follows the counters
  assign rd_row = row_q;
  assign rd_col = col_q;

  ////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_q.valid <= 1'b0;
    end else begin
      fetch_q.valid <= active_q;
      fetch_q.row   <= row_q;
      // Row boundary flags for the accumulator
      fetch_q.first <= (col_q == '0);
      fetch_q.last  <= col_last;
      fetch_q.u     <= u_word;
      fetch_q.h     <= h_word;
    end
  end

  assign fetch = fetch_q;

endmodule

/* design/ntm_output_apb_regs.sv */
`timescale 1ns/1ns

module ntm_output_apb_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [9:0]                paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      start,
  output ntm_output_pkg::ntm_size_t size_y,
  output ntm_output_pkg::ntm_size_t size_l,
  input  ntm_output_pkg::ntm_idx_t  rd_row,
  input  ntm_output_pkg::ntm_idx_t  rd_col,
  output ntm_output_pkg::ntm_data_t u_word,
  output ntm_output_pkg::ntm_data_t h_word,
  input  logic                      done,
  output ntm_output_pkg::ntm_idx_t  nu_addr,
  input  ntm_output_pkg::ntm_data_t nu_word
);
  import ntm_output_pkg::*;

  ntm_apb_addr_u addr;
  ntm_idx_t      word_idx;
  ntm_data_t     u_mem [ntm_max_dim*ntm_max_dim];
  ntm_data_t     h_mem [ntm_max_dim];
  logic          run_q;
  logic          busy;
  logic          nu_wait_q;
  logic          access;
  logic          is_nu;
  logic          size_ok;
  logic          wr_err;
  logic          wr_fire;

  ////////////////////////////////////////////////////////////
  // Address decode and handshake
  ////////////////////////////////////////////////////////////

  assign addr     = paddr;
  assign word_idx = addr.reg_view.word[2:0];
  assign access   = psel & penable;
  assign is_nu    = (addr.reg_view.region == region_nu_vec);

  // Result memory read is registered so nu needs one wait state
  assign pready = access & (~is_nu | nu_wait_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nu_wait_q <= 1'b0;
    end else begin
      nu_wait_q <= access & is_nu & ~nu_wait_q;
    end
  end

  // Busy drops in the same cycle done rises
  assign busy = run_q & ~done;

  // Legal sizes are 1 to 8
  assign size_ok = (pwdata != 32'd0) && (pwdata <= 32'(ntm_max_dim));

  always_comb begin
    wr_err = 1'b0;
    case (addr.reg_view.region)
      region_ctrl: begin
        if (addr.reg_view.word == reg_status) begin
          wr_err = 1'b1;
        end else if (addr.reg_view.word == reg_size_y || addr.reg_view.word == reg_size_l) begin
          wr_err = busy | ~size_ok;
        end
      end
      region_u_mat,
      region_h_vec:  wr_err = busy;
      region_nu_vec: wr_err = 1'b1;
      default:       wr_err = 1'b0;
    endcase
  end

  assign pslverr = pready & pwrite & wr_err;
  assign wr_fire = pready & pwrite & ~wr_err;

  ////////////////////////////////////////////////////////////
  // Registers and operand memories
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start  <= 1'b0;
      run_q  <= 1'b0;
      size_y <= 4'd1;
      size_l <= 4'd1;
      for (int i = 0; i < ntm_max_dim*ntm_max_dim; i++) begin
        u_mem[i] <= '0;
      end
      for (int i = 0; i < ntm_max_dim; i++) begin
        h_mem[i] <= '0;
      end
    end else begin
      // Start is a single cycle pulse
      start <= 1'b0;
      if (start) begin
        run_q <= 1'b1;
      end else if (done) begin
        run_q <= 1'b0;
      end
      if (wr_fire) begin
        case (addr.reg_view.region)
          region_ctrl: begin
            // Start while busy is dropped silently
            if (addr.reg_view.word == reg_ctrl && pwdata[0] && !busy) begin
              start <= 1'b1;
            end
            if (addr.reg_view.word == reg_size_y) begin
              size_y <= pwdata[3:0];
            end
            if (addr.reg_view.word == reg_size_l) begin
              size_l <= pwdata[3:0];
            end
          end
          region_u_mat: begin
            u_mem[{addr.mat_view.row, addr.mat_view.col}] <= pwdata[ntm_data_width-1:0];
          end
          region_h_vec: begin
            h_mem[word_idx] <= pwdata[ntm_data_width-1:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Read data mux
  always_comb begin
    prdata = '0;
    case (addr.reg_view.region)
      region_ctrl: begin
        if (addr.reg_view.word == reg_status) begin
          prdata = {30'd0, done, busy};
        end else if (addr.reg_view.word == reg_size_y) begin
          prdata = 32'(size_y);
        end else if (addr.reg_view.word == reg_size_l) begin
          prdata = 32'(size_l);
        end
      end
      region_u_mat:  prdata = 32'(u_mem[{addr.mat_view.row, addr.mat_view.col}]);
      region_h_vec:  prdata = 32'(h_mem[word_idx]);
      region_nu_vec: prdata = 32'(nu_word);
      default:       prdata = '0;
    endcase
  end

  // Fetch side read ports
  assign u_word  = u_mem[{rd_row, rd_col}];
  assign h_word  = h_mem[rd_col];
  assign nu_addr = word_idx;

endmodule

/* design/ntm_output_pkg.sv */
package ntm_output_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Element width and largest matrix dimension
  localparam int ntm_data_width = 16;
  localparam int ntm_max_dim    = 8;

  typedef logic [2:0]                ntm_idx_t;
  typedef logic [3:0]                ntm_size_t;
  typedef logic [ntm_data_width-1:0] ntm_data_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  // Top two address bits select the window
  typedef enum logic [1:0] {
    region_ctrl   = 2'd0,
    region_u_mat  = 2'd1,
    region_h_vec  = 2'd2,
    region_nu_vec = 2'd3
  } ntm_region_e;

  // Word indices inside the control window
  localparam logic [5:0] reg_ctrl   = 6'd0;
  localparam logic [5:0] reg_status = 6'd1;
  localparam logic [5:0] reg_size_y = 6'd2;
  localparam logic [5:0] reg_size_l = 6'd3;

  // Flat word view for registers and vectors
  typedef struct packed {
    ntm_region_e region;
    logic [5:0]  word;
    logic [1:0]  byte_off;
  } ntm_reg_view_s;

  // Row and column view for the U matrix
  typedef struct packed {
    ntm_region_e region;
    ntm_idx_t    row;
    ntm_idx_t    col;
    logic [1:0]  byte_off;
  } ntm_mat_view_s;

  typedef union packed {
    ntm_reg_view_s reg_view;
    ntm_mat_view_s mat_view;
  } ntm_apb_addr_u;

  ////////////////////////////////////////////////////////////
  // Stage records
  ////////////////////////////////////////////////////////////

  // Fetch to MAC
  typedef struct packed {
    logic      valid;
    ntm_idx_t  row;
    logic      first;
    logic      last;
    ntm_data_t u;
    ntm_data_t h;
  } ntm_fetch_s;

  // MAC to writeback
  typedef struct packed {
    logic      valid;
    ntm_idx_t  row;
    ntm_data_t value;
  } ntm_nu_s;

endpackage
